//--- all.f
+incdir+.
exu_pkg.sv
alu.sv
lsu_align.sv
exu.sv
reg_file.sv
data_mem.sv
exu_top.sv
tb_exu_sva.sv
tb_exu_top.sv

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exu_pkg::word_t   a,
    input  exu_pkg::word_t   b,
    input  exu_pkg::alu_op_e op,
    output exu_pkg::word_t   res
);
    import exu_pkg::*;

    // shift amount from low five bits of b
    logic [4:0] shamt;
    // compare result, bit 0 only
    logic       cmp;

    assign shamt = b[4:0];

    // ----------------------------------------------------------------------
    // compare path
    // ----------------------------------------------------------------------
    always_comb begin
        case (op)
            alu_slt, alu_lt: cmp = $signed(a) < $signed(b);
            alu_sltu, alu_ltu: cmp = a < b;
            alu_eq: cmp = a == b;
            alu_ne: cmp = a != b;
            alu_ge: cmp = $signed(a) >= $signed(b);
            alu_geu: cmp = a >= b;
            default: cmp = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // result select
    // ----------------------------------------------------------------------
    always_comb begin
        case (op)
            alu_add: res = a + b;
            alu_sub: res = a - b;
            alu_sll: res = a << shamt;
            alu_xor: res = a ^ b;
            alu_srl: res = a >> shamt;
            // arithmetic shift keeps the sign
            alu_sra: res = word_t'($signed(a) >>> shamt);
            alu_or: res = a | b;
            alu_and: res = a & b;
            // slt, sltu and all branch compares
            default: res = {{($bits(word_t) - 1){1'b0}}, cmp};
        endcase
    end

endmodule

`default_nettype wire

//--- data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module data_mem (
    input  logic             clk,
    input  logic             we,
    input  exu_pkg::word_t   addr,
    input  exu_pkg::wmask_t  wmask,
    input  exu_pkg::word_t   wdata,
    output exu_pkg::word_t   rdata
);
    import exu_pkg::*;

    localparam int DEPTH = 1 << `EXU_DMEM_AW;

    word_t                   mem [DEPTH];
    // word index, byte offset dropped
    logic [`EXU_DMEM_AW-1:0] idx;

    assign idx = addr[`EXU_DMEM_AW+1:2];

    // per lane write
    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(wmask_t); i++) begin
            if (we && wmask[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  exu_pkg::exu_op_t op,
    input  exu_pkg::word_t   pc,
    input  exu_pkg::word_t   rs1_data,
    input  exu_pkg::word_t   rs2_data,
    input  exu_pkg::word_t   mem_rdata,
    output exu_pkg::word_t   mem_addr,
    output logic             mem_we,
    output exu_pkg::wmask_t  mem_wmask,
    output exu_pkg::word_t   mem_wdata,
    output exu_pkg::word_t   next_pc,
    output exu_pkg::word_t   wb_data,
    output exu_pkg::word_t   csr_wdata
);
    import exu_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_res;
    word_t load_data;
    word_t pc_plus4;
    word_t pc_target;
    word_t jalr_target;
    logic  is_load;

    // ----------------------------------------------------------------------
    // alu
    // ----------------------------------------------------------------------
    always_comb begin
        case (op.src_sel)
            // lui
            src_imm_zero: begin
                alu_a = op.imm;
                alu_b = '0;
            end
            // auipc
            src_pc_imm: begin
                alu_a = pc;
                alu_b = op.imm;
            end
            src_rs1_rs2: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = op.imm;
            end
        endcase
    end

    alu u_alu (
        .a   (alu_a),
        .b   (alu_b),
        .op  (op.alu_op),
        .res (alu_res)
    );

    // ----------------------------------------------------------------------
    // next pc
    // ----------------------------------------------------------------------
    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + op.imm;
    // jalr clears bit 0 of the sum
    assign jalr_target = (rs1_data + op.imm) & ~32'd1;

    always_comb begin
        case (op.pc_sel)
            pc_branch: next_pc = alu_res[0] ? pc_target : pc_plus4;
            pc_jal: next_pc = pc_target;
            pc_jalr: next_pc = jalr_target;
            // return target comes in on rs2
            pc_mret: next_pc = rs2_data;
            default: next_pc = pc_plus4;
        endcase
    end

    // ----------------------------------------------------------------------
    // memory
    // ----------------------------------------------------------------------
    // address is always the alu sum
    assign mem_addr = alu_res;
    assign mem_we   = (op.mem_size != mem_none) && op.mem_write;
    assign is_load  = (op.mem_size != mem_none) && !op.mem_write;

    lsu_align u_lsu_align (
        .addr_lo    (alu_res[1:0]),
        .size       (op.mem_size),
        .is_signed  (op.mem_signed),
        .store_data (rs2_data),
        .load_word  (mem_rdata),
        .wmask      (mem_wmask),
        .wdata      (mem_wdata),
        .load_data  (load_data)
    );

    // ----------------------------------------------------------------------
    // writeback
    // ----------------------------------------------------------------------
    assign wb_data   = op.link ? pc_plus4 : (is_load ? load_data : alu_res);
    // csr value only reported
    assign csr_wdata = rs2_data;

endmodule

`default_nettype wire

//--- exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width, one machine word
`define EXU_XLEN 32

// register index width, 32 architectural registers
`define EXU_NREG_LOG2 5

// data memory word address bits, 256 words
`define EXU_DMEM_AW 8

// first pc after reset
`define EXU_RESET_PC 32'h8000_0000

`endif

//--- exu_pkg.sv
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

    // ----------------------------------------------------------------------
    // basic widths
    // ----------------------------------------------------------------------
    typedef logic [`EXU_XLEN-1:0] word_t;
    typedef logic [`EXU_NREG_LOG2-1:0] reg_idx_t;
    // one enable bit per byte lane
    typedef logic [`EXU_XLEN/8-1:0] wmask_t;

    // ----------------------------------------------------------------------
    // decoded control fields
    // ----------------------------------------------------------------------
    // compares leave 0 or 1 in bit 0
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and, alu_eq, alu_ne,
        alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_op_e;

    // operand pair into the alu
    typedef enum logic [1:0] {
        src_imm_zero, src_pc_imm, src_rs1_rs2, src_rs1_imm
    } src_sel_e;

    // next pc rule
    typedef enum logic [2:0] {
        pc_seq, pc_branch, pc_jal, pc_jalr, pc_mret
    } pc_sel_e;

    typedef enum logic [1:0] {
        mem_none, mem_byte, mem_half, mem_word
    } mem_size_e;

    // one decoded instruction per cycle
    typedef struct packed {
        alu_op_e   alu_op;
        src_sel_e  src_sel;
        pc_sel_e   pc_sel;
        mem_size_e mem_size;
        logic      mem_write;
        logic      mem_signed;
        logic      link;
        logic      ebreak;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        logic      rd_we;
    } exu_op_t;

    // retire record, one cycle after accept
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rd_data;
        word_t    csr_wdata;
    } retire_t;

endpackage

`default_nettype wire

//--- exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module exu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid,
    input  exu_pkg::exu_op_t op,
    output exu_pkg::retire_t retire,
    output logic             halt,
    output exu_pkg::word_t   halt_code
);
    import exu_pkg::*;

    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;
    word_t  next_pc;
    word_t  wb_data;
    word_t  csr_wdata;
    wmask_t mem_wmask;
    logic   mem_we;
    // instruction taken this cycle
    logic   accept;

    assign accept = valid && !halt && !rst;

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    reg_file u_reg_file (
        .clk    (clk),
        .we     (accept && op.rd_we),
        .waddr  (op.rd),
        .wdata  (wb_data),
        .raddr1 (op.rs1),
        .raddr2 (op.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exu u_exu (
        .op        (op),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wmask (mem_wmask),
        .mem_wdata (mem_wdata),
        .next_pc   (next_pc),
        .wb_data   (wb_data),
        .csr_wdata (csr_wdata)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .we    (accept && mem_we),
        .addr  (mem_addr),
        .wmask (mem_wmask),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // ----------------------------------------------------------------------
    // pc, halt and retire
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `EXU_RESET_PC;
            halt         <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= accept;
            if (accept) begin
                pc                <= next_pc;
                retire.pc         <= pc;
                retire.next_pc    <= next_pc;
                retire.rd         <= op.rd;
                retire.rd_we      <= op.rd_we;
                retire.rd_data    <= wb_data;
                retire.csr_wdata  <= csr_wdata;
                // ebreak parks the core, exit code from rs1
                if (op.ebreak) begin
                    halt      <= 1'b1;
                    halt_code <= rs1_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- lsu_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  logic [1:0]          addr_lo,
    input  exu_pkg::mem_size_e  size,
    input  logic                is_signed,
    input  exu_pkg::word_t      store_data,
    input  exu_pkg::word_t      load_word,
    output exu_pkg::wmask_t     wmask,
    output exu_pkg::word_t      wdata,
    output exu_pkg::word_t      load_data
);
    import exu_pkg::*;

    // bit offset of the addressed byte
    logic [4:0] shift;
    // load word moved down to bit 0
    word_t      load_shifted;

    assign shift = {addr_lo, 3'b000};

    // ----------------------------------------------------------------------
    // store side
    // ----------------------------------------------------------------------
    // data lands in its byte lane, mask picks the lanes
    assign wdata = store_data << shift;

    always_comb begin
        case (size)
            mem_byte: wmask = wmask_t'(4'b0001 << addr_lo);
            mem_half: wmask = addr_lo[1] ? 4'b1100 : 4'b0011;
            mem_word: wmask = 4'b1111;
            default: wmask = 4'b0000;
        endcase
    end

    // ----------------------------------------------------------------------
    // load side
    // ----------------------------------------------------------------------
    assign load_shifted = load_word >> shift;

    always_comb begin
        case (size)
            // lb / lbu
            mem_byte: load_data = {{24{is_signed & load_shifted[7]}}, load_shifted[7:0]};
            // lh / lhu
            mem_half: load_data = {{16{is_signed & load_shifted[15]}}, load_shifted[15:0]};
            default: load_data = load_shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module reg_file (
    input  logic                clk,
    input  logic                we,
    input  exu_pkg::reg_idx_t   waddr,
    input  exu_pkg::word_t      wdata,
    input  exu_pkg::reg_idx_t   raddr1,
    input  exu_pkg::reg_idx_t   raddr2,
    output exu_pkg::word_t      rdata1,
    output exu_pkg::word_t      rdata2
);
    import exu_pkg::*;

    localparam int NREG = 1 << `EXU_NREG_LOG2;

    word_t regs [NREG];

    // x0 writes dropped
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the exu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exu_top -f all.f -o tb_exu_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_exu_top_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_exu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_sva (
    input logic             clk,
    input logic             rst,
    input logic             halt,
    input exu_pkg::retire_t retire,
    input exu_pkg::word_t   pc
);
    // failures seen by the properties below, read by the testbench
    int err_count = 0;

    // ----------------------------------------------------------------------
    // reset state
    // ----------------------------------------------------------------------
    // nothing retired and core running right after reset
    reset_clears: assert property (@(posedge clk) rst |=> (!retire.valid && !halt))
        else begin
            $error("retire.valid or halt still set in the cycle after reset");
            err_count++;
        end

    // ----------------------------------------------------------------------
    // halt and pc
    // ----------------------------------------------------------------------
    // halt is sticky until the next reset
    halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else begin
            $error("halt dropped without a reset");
            err_count++;
        end

    // jalr clears bit 0, so pc stays even
    pc_even: assert property (@(posedge clk) disable iff (rst) retire.valid |-> !pc[0])
        else begin
            $error("pc bit 0 set after a retire");
            err_count++;
        end

endmodule

bind exu_top tb_exu_sva u_exu_sva (
    .clk    (clk),
    .rst    (rst),
    .halt   (halt),
    .retire (retire),
    .pc     (pc)
);

`default_nettype wire

//--- tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_cfg.svh"

module tb_exu_top;
    import exu_pkg::*;

    localparam int RETIRE_TIMEOUT = 20;

    logic     clk;
    logic     rst;
    logic     valid;
    exu_op_t  op;
    retire_t  retire;
    logic     halt;
    word_t    halt_code;

    // reference state
    word_t      regs_m [32];
    logic [7:0] mem_m [1024];
    word_t      pc_m;

    int    checks;
    int    errors;
    int    tests;
    int    test_checks0;
    int    test_errors0;
    string test_name;

    exu_top u_exu_top (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .retire    (retire),
        .halt      (halt),
        .halt_code (halt_code)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic word_t rv(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        return regs_m[idx];
    endfunction

    // rv32i semantics with compares giving 0 or 1
    function automatic word_t alu_ref(input alu_op_e f, input word_t a, input word_t b);
        word_t              r;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f)
            alu_add: r = a + b;
            alu_sub: r = a + ~b + 32'd1;
            alu_sll: r = a << b[4:0];
            alu_slt, alu_lt: r = word_t'(sa < sb);
            alu_sltu, alu_ltu: r = word_t'(a < b);
            alu_xor: r = a ^ b;
            alu_srl: r = a >> b[4:0];
            alu_sra: r = word_t'(sa >>> b[4:0]);
            alu_or: r = a | b;
            alu_and: r = a & b;
            alu_eq: r = word_t'(a == b);
            alu_ne: r = word_t'(a != b);
            alu_ge: r = word_t'(!(sa < sb));
            default: r = word_t'(!(a < b));
        endcase
        return r;
    endfunction

    // byte-addressed load with extension
    function automatic word_t load_ref(input int addr, input mem_size_e sz, input logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        b = mem_m[addr];
        h = {mem_m[addr + 1], mem_m[addr]};
        case (sz)
            mem_byte: w = {{24{sgn & b[7]}}, b};
            mem_half: w = {{16{sgn & h[15]}}, h};
            default: w = {mem_m[addr + 3], mem_m[addr + 2], mem_m[addr + 1], mem_m[addr]};
        endcase
        return w;
    endfunction

    function automatic int size_bytes(input mem_size_e sz);
        case (sz)
            mem_byte: return 1;
            mem_half: return 2;
            mem_word: return 4;
            default: return 0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // checks and reporting
    // ----------------------------------------------------------------------
    task automatic check(input string field, input word_t exp, input word_t act);
        checks++;
        assert (act == exp) else begin
            $display("Fail %s %s: expected %h actual %h", test_name, field, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done: %0d checks, %0d errors", test_name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    // plain add rd = rs1 + imm with sequential pc and no memory
    function automatic exu_op_t base_op();
        exu_op_t o;
        o = '0;
        o.alu_op   = alu_add;
        o.src_sel  = src_rs1_imm;
        o.pc_sel   = pc_seq;
        o.mem_size = mem_none;
        return o;
    endfunction

    // ----------------------------------------------------------------------
    // one instruction through the dut
    // ----------------------------------------------------------------------
    task automatic run_op(input exu_op_t o);
        word_t a;
        word_t b;
        word_t res;
        word_t exp_wb;
        word_t exp_next;
        word_t jump;
        word_t sdata;
        int    maddr;
        int    waited;
        logic  is_load;
        case (o.src_sel)
            src_imm_zero: begin
                a = o.imm;
                b = '0;
            end
            src_pc_imm: begin
                a = pc_m;
                b = o.imm;
            end
            src_rs1_rs2: begin
                a = rv(o.rs1);
                b = rv(o.rs2);
            end
            default: begin
                a = rv(o.rs1);
                b = o.imm;
            end
        endcase
        res     = alu_ref(o.alu_op, a, b);
        maddr   = int'(res[9:0]);
        is_load = (o.mem_size != mem_none) && !o.mem_write;
        jump    = rv(o.rs1) + o.imm;
        if (o.link) begin
            exp_wb = pc_m + 32'd4;
        end else if (is_load) begin
            exp_wb = load_ref(maddr, o.mem_size, o.mem_signed);
        end else begin
            exp_wb = res;
        end
        case (o.pc_sel)
            pc_branch: exp_next = res[0] ? pc_m + o.imm : pc_m + 32'd4;
            pc_jal: exp_next = pc_m + o.imm;
            pc_jalr: exp_next = {jump[31:1], 1'b0};
            pc_mret: exp_next = rv(o.rs2);
            default: exp_next = pc_m + 32'd4;
        endcase

        @(negedge clk);
        valid = 1'b1;
        op    = o;
        @(negedge clk);
        valid  = 1'b0;
        waited = 0;
        while (!retire.valid && waited < RETIRE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!retire.valid) begin
            $display("timeout: instruction in test %s never retired", test_name);
            $display("TB FAILED");
            $finish;
        end else begin
            check("pc", pc_m, retire.pc);
            check("next_pc", exp_next, retire.next_pc);
            check("csr_wdata", rv(o.rs2), retire.csr_wdata);
            check("rd", word_t'(o.rd), word_t'(retire.rd));
            check("rd_we", word_t'(o.rd_we), word_t'(retire.rd_we));
            if (o.rd_we) begin
                check("rd_data", exp_wb, retire.rd_data);
            end
            // update the model after the compare
            if (o.mem_size != mem_none && o.mem_write) begin
                sdata = rv(o.rs2);
                for (int k = 0; k < size_bytes(o.mem_size); k++) begin
                    mem_m[maddr + k] = sdata[8*k +: 8];
                end
            end
            if (o.rd_we && o.rd != '0) begin
                regs_m[o.rd] = exp_wb;
            end
            pc_m = exp_next;
        end
    endtask

    task automatic set_reg(input reg_idx_t idx, input word_t val);
        exu_op_t o;
        o         = base_op();
        o.src_sel = src_imm_zero;
        o.imm     = val;
        o.rd      = idx;
        o.rd_we   = 1'b1;
        run_op(o);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        exu_op_t   o;
        mem_size_e sz;
        int        step;
        int        late;
        int        pair_a [5];
        int        pair_b [5];
        int        total_errors;

        pair_a   = '{10, 10, 13, 12, 10};
        pair_b   = '{11, 13, 10, 10, 12};
        void'($urandom(32'h91b6));
        clk      = 1'b0;
        rst      = 1'b1;
        valid    = 1'b0;
        op       = base_op();
        pc_m     = `EXU_RESET_PC;
        checks   = 0;
        errors   = 0;
        tests    = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // random alu traffic over all 16 ops
        start_test("alu");
        for (int i = 1; i < 32; i++) begin
            set_reg(reg_idx_t'(i), $urandom());
        end
        for (int i = 0; i < 40; i++) begin
            o         = base_op();
            o.alu_op  = alu_op_e'(i % 16);
            o.src_sel = ($urandom() & 1) ? src_rs1_rs2 : src_rs1_imm;
            o.rd      = (i % 8 == 3) ? 5'd0 : reg_idx_t'($urandom_range(31, 1));
            o.rs1     = reg_idx_t'($urandom_range(31, 1));
            o.rs2     = reg_idx_t'($urandom_range(31, 1));
            o.imm     = $urandom();
            o.rd_we   = 1'b1;
            run_op(o);
        end
        // x0 reads back zero after the writes above
        o       = base_op();
        o.rd    = 5'd7;
        o.rd_we = 1'b1;
        run_op(o);
        end_test();

        // branches both ways plus jal and jalr
        start_test("control");
        set_reg(5'd10, 32'd5);
        set_reg(5'd11, 32'd5);
        set_reg(5'd12, 32'hffff_fffd);
        set_reg(5'd13, 32'd7);
        set_reg(5'd14, 32'h8000_1001);
        for (int c = 10; c < 16; c++) begin
            for (int p = 0; p < 5; p++) begin
                o         = base_op();
                o.alu_op  = alu_op_e'(c);
                o.src_sel = src_rs1_rs2;
                o.pc_sel  = pc_branch;
                o.rs1     = reg_idx_t'(pair_a[p]);
                o.rs2     = reg_idx_t'(pair_b[p]);
                o.imm     = p[0] ? 32'hffff_ffe0 : 32'h0000_0040;
                run_op(o);
            end
        end
        o         = base_op();
        o.src_sel = src_pc_imm;
        o.pc_sel  = pc_jal;
        o.link    = 1'b1;
        o.rd      = 5'd1;
        o.rd_we   = 1'b1;
        o.imm     = 32'h0000_0100;
        run_op(o);
        // odd target so bit 0 must drop
        o        = base_op();
        o.pc_sel = pc_jalr;
        o.link   = 1'b1;
        o.rs1    = 5'd14;
        o.rd     = 5'd2;
        o.rd_we  = 1'b1;
        o.imm    = 32'h0000_0004;
        run_op(o);
        end_test();

        // every size at every legal offset followed by signed and unsigned loads
        start_test("memory");
        set_reg(5'd20, 32'h8a7b_96c5);
        set_reg(5'd21, 32'h1234_5678);
        for (int d = 20; d < 22; d++) begin
            for (int s = 1; s < 4; s++) begin
                sz   = mem_size_e'(s);
                step = size_bytes(sz);
                for (int off = 0; off < 4; off += step) begin
                    o           = base_op();
                    o.mem_size  = sz;
                    o.mem_write = 1'b1;
                    o.rs2       = reg_idx_t'(d);
                    o.imm       = 32'h0000_0200 + word_t'(16 * s + off);
                    run_op(o);
                    o.mem_write = 1'b0;
                    o.rs2       = 5'd0;
                    o.rd        = 5'd22;
                    o.rd_we     = 1'b1;
                    o.mem_signed = 1'b1;
                    run_op(o);
                    o.mem_signed = 1'b0;
                    run_op(o);
                end
            end
        end
        end_test();

        // lui and auipc
        start_test("upper");
        o         = base_op();
        o.src_sel = src_imm_zero;
        o.imm     = 32'hdead_b000;
        o.rd      = 5'd3;
        o.rd_we   = 1'b1;
        run_op(o);
        o.src_sel = src_pc_imm;
        o.imm     = 32'h0001_2000;
        o.rd      = 5'd4;
        run_op(o);
        end_test();

        // return target and csr value both come from rs2
        start_test("mret");
        set_reg(5'd15, 32'h8000_0200);
        o        = base_op();
        o.pc_sel = pc_mret;
        o.rs2    = 5'd15;
        run_op(o);
        end_test();

        start_test("ebreak");
        set_reg(5'd8, 32'h0000_002a);
        o        = base_op();
        o.ebreak = 1'b1;
        o.rs1    = 5'd8;
        run_op(o);
        check("halt", 32'd1, word_t'(halt));
        check("halt_code", rv(5'd8), halt_code);
        // offered after halt and must be dropped
        o         = base_op();
        o.src_sel = src_imm_zero;
        o.imm     = 32'h5555_aaaa;
        o.rd      = 5'd9;
        o.rd_we   = 1'b1;
        @(negedge clk);
        valid = 1'b1;
        op    = o;
        late  = 0;
        for (int w = 0; w < 5; w++) begin
            @(negedge clk);
            if (retire.valid) begin
                late = 1;
            end
        end
        valid = 1'b0;
        check("retire_after_halt", 32'd0, word_t'(late));
        for (int i = 1; i < 32; i++) begin
            check("reg_after_halt", regs_m[i], u_exu_top.u_reg_file.regs[i]);
        end
        end_test();

        total_errors = errors + u_exu_top.u_exu_sva.err_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_exu_top.u_exu_sva.err_count);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
